//--- common/hsid_pkg.sv
package hsid_pkg;

  // Bus and sample widths
  localparam int HSID_WORD_WIDTH = 32;  // One OBI data word
  localparam int HSID_DATA_WIDTH = 16;  // One band sample, two per word

  // Default sizes for the configuration ports
  localparam int HSID_HSP_BANDS_WIDTH = 7;  // Band count, up to 64 bands
  localparam int HSID_HSP_LIBRARY_WIDTH = 12;  // Library entries and burst words

  // Sum of up to 64 squared 17-bit differences fits with margin
  localparam int HSID_MSE_WIDTH = 40;

  // Control FSM, one burst for the captured pixel and one for the library
  typedef enum logic [2:0] {
    OR_IDLE,
    START_READ_CAPTURED,  // Load captured address and length
    READ_CAPTURED,
    START_READ_LIBRARY,  // Load library address and length
    READ_LIBRARY
  } hsid_x_obi_read_t;

  // Burst read master
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,  // Requests still to be granted
    RD_WAIT_LAST  // All granted, waiting for rvalid
  } hsid_obi_rd_state_t;

endpackage

//--- hdl/hsid_x_top_fsm.sv
`timescale 1ns/1ps

module hsid_x_top_fsm #(
  parameter int WORD_WIDTH = hsid_pkg::HSID_WORD_WIDTH,
  parameter int HSP_BANDS_WIDTH = hsid_pkg::HSID_HSP_BANDS_WIDTH,
  parameter int HSP_LIBRARY_WIDTH = hsid_pkg::HSID_HSP_LIBRARY_WIDTH
) (
  input  logic clk,
  input  logic rst_n,

  input  logic [HSP_BANDS_WIDTH-1:0] pixel_bands,
  input  logic [HSP_LIBRARY_WIDTH-1:0] library_size,
  input  logic [WORD_WIDTH-1:0] captured_pixel_addr,
  input  logic [WORD_WIDTH-1:0] library_pixel_addr,
  input  logic start,

  output logic [WORD_WIDTH-1:0] obi_initial_addr,
  output logic [HSP_LIBRARY_WIDTH-1:0] obi_limit_in,
  output logic obi_start,
  input  logic obi_done,

  output logic library_phase,
  output logic [HSP_BANDS_WIDTH-2:0] words_per_pixel,
  output logic run_start,
  output logic run_end,
  output logic busy,
  output logic error
);

  import hsid_pkg::*;

  localparam int PACK_WIDTH = HSP_BANDS_WIDTH - 1;  // Words per pixel

  hsid_x_obi_read_t state;
  hsid_x_obi_read_t next_state;

  logic bands_ok;
  logic start_ok;
  logic [PACK_WIDTH+HSP_LIBRARY_WIDTH-1:0] library_words;

  // Even, non-zero band count and a non-empty library
  assign bands_ok = (pixel_bands != '0) && !pixel_bands[0] && (library_size != '0);
  assign start_ok = start && (state == OR_IDLE) && bands_ok;
  assign library_words = words_per_pixel * library_size;

  assign library_phase = (state == START_READ_LIBRARY) || (state == READ_LIBRARY);
  assign run_end = (state == READ_LIBRARY) && obi_done;
  assign busy = (state != OR_IDLE);

  always_comb begin
    next_state = state;
    case (state)
      OR_IDLE:             if (start_ok) next_state = START_READ_CAPTURED;
      START_READ_CAPTURED: next_state = READ_CAPTURED;
      READ_CAPTURED:       if (obi_done) next_state = START_READ_LIBRARY;
      START_READ_LIBRARY:  next_state = READ_LIBRARY;
      READ_LIBRARY:        if (obi_done) next_state = OR_IDLE;
      default:             next_state = OR_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= OR_IDLE;
      obi_start <= 1'b0;
      run_start <= 1'b0;
      error <= 1'b0;
    end else begin
      state <= next_state;
      obi_start <= (state == START_READ_CAPTURED) || (state == START_READ_LIBRARY);  // One pulse
      run_start <= start_ok;
      error <= start && (state == OR_IDLE) && !bands_ok;  // Ignored while busy
    end
  end

  // Burst setup, loaded in the two START states
  always_ff @(posedge clk) begin
    if (start_ok) begin
      words_per_pixel <= pixel_bands[HSP_BANDS_WIDTH-1:1];  // Two bands per word
    end
    if (state == START_READ_CAPTURED) begin
      obi_initial_addr <= captured_pixel_addr;
      obi_limit_in <= {{(HSP_LIBRARY_WIDTH-PACK_WIDTH){1'b0}}, words_per_pixel};
    end else if (state == START_READ_LIBRARY) begin
      obi_initial_addr <= library_pixel_addr;
      obi_limit_in <= library_words[HSP_LIBRARY_WIDTH-1:0];  // Whole library in one burst
    end
  end

endmodule

//--- obi_reader/hsid_obi_reader.sv
`timescale 1ns/1ps

module hsid_obi_reader #(
  parameter int WORD_WIDTH = hsid_pkg::HSID_WORD_WIDTH,
  parameter int HSP_LIBRARY_WIDTH = hsid_pkg::HSID_HSP_LIBRARY_WIDTH
) (
  input  logic clk,
  input  logic rst_n,

  input  logic [WORD_WIDTH-1:0] obi_initial_addr,
  input  logic [HSP_LIBRARY_WIDTH-1:0] obi_limit_in,
  input  logic obi_start,

  output logic obi_req,
  output logic [WORD_WIDTH-1:0] obi_addr,
  input  logic obi_gnt,
  input  logic obi_rvalid,
  input  logic [WORD_WIDTH-1:0] obi_rdata,

  output logic obi_done,
  output logic word_valid,
  output logic [WORD_WIDTH-1:0] word_data
);

  import hsid_pkg::*;

  localparam logic [WORD_WIDTH-1:0] ADDR_STEP = WORD_WIDTH / 8;  // Bytes per word
  localparam logic [HSP_LIBRARY_WIDTH-1:0] CNT_ONE = 1;

  hsid_obi_rd_state_t state;

  logic [HSP_LIBRARY_WIDTH-1:0] limit;
  logic [HSP_LIBRARY_WIDTH-1:0] gnt_cnt;  // Requests granted so far
  logic [HSP_LIBRARY_WIDTH-1:0] rcv_cnt;  // Responses returned so far
  logic last_gnt;
  logic last_rcv;

  assign obi_req = (state == RD_REQ);
  assign last_gnt = obi_gnt && (gnt_cnt + CNT_ONE == limit);
  assign last_rcv = word_valid && (rcv_cnt + CNT_ONE == limit);

  // Responses arrive in grant order, so data passes straight on
  assign word_valid = obi_rvalid && (state != RD_IDLE);
  assign word_data = obi_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RD_IDLE;
      gnt_cnt <= '0;
      rcv_cnt <= '0;
      obi_done <= 1'b0;
    end else begin
      obi_done <= 1'b0;
      if (word_valid) rcv_cnt <= rcv_cnt + CNT_ONE;
      case (state)
        RD_IDLE: begin
          if (obi_start) begin
            gnt_cnt <= '0;
            rcv_cnt <= '0;
            if (obi_limit_in == '0) obi_done <= 1'b1;  // Empty burst ends at once
            else state <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (obi_gnt) begin
            gnt_cnt <= gnt_cnt + CNT_ONE;
            if (last_gnt) state <= RD_WAIT_LAST;
          end
        end
        RD_WAIT_LAST: begin
          if (last_rcv) begin
            state <= RD_IDLE;
            obi_done <= 1'b1;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == RD_IDLE) && obi_start) begin
      obi_addr <= obi_initial_addr;
      limit <= obi_limit_in;
    end else if (obi_req && obi_gnt) begin
      obi_addr <= obi_addr + ADDR_STEP;  // Held until granted
    end
  end

endmodule

//--- hdl/hsid_mse_unit.sv
`timescale 1ns/1ps

module hsid_mse_unit #(
  parameter int WORD_WIDTH = hsid_pkg::HSID_WORD_WIDTH,
  parameter int DATA_WIDTH = hsid_pkg::HSID_DATA_WIDTH,
  parameter int HSP_BANDS_WIDTH = hsid_pkg::HSID_HSP_BANDS_WIDTH,
  parameter int HSP_LIBRARY_WIDTH = hsid_pkg::HSID_HSP_LIBRARY_WIDTH,
  parameter int MSE_WIDTH = hsid_pkg::HSID_MSE_WIDTH
) (
  input  logic clk,
  input  logic rst_n,

  input  logic word_valid,
  input  logic [WORD_WIDTH-1:0] word_data,
  input  logic library_phase,
  input  logic [HSP_BANDS_WIDTH-2:0] words_per_pixel,
  input  logic run_start,
  input  logic run_end,
  input  logic clear,

  output logic result_valid,
  output logic [MSE_WIDTH-1:0] min_mse,
  output logic [HSP_LIBRARY_WIDTH-1:0] min_index
);

  localparam int PACK_WIDTH = HSP_BANDS_WIDTH - 1;
  localparam int BUF_DEPTH = 2 ** (HSP_BANDS_WIDTH - 2);  // 32 words for 64 bands
  localparam int BUF_AW = $clog2(BUF_DEPTH);
  localparam int SQ_WIDTH = 2 * (DATA_WIDTH + 1);  // Square of a 17-bit difference
  localparam logic [PACK_WIDTH-1:0] WCNT_ONE = 1;
  localparam logic [HSP_LIBRARY_WIDTH-1:0] IDX_ONE = 1;

  logic [WORD_WIDTH-1:0] captured_buf [BUF_DEPTH];
  logic [WORD_WIDTH-1:0] ref_word;
  logic [PACK_WIDTH-1:0] word_cnt;  // Word position inside the pixel
  logic [HSP_LIBRARY_WIDTH-1:0] entry_idx;
  logic [MSE_WIDTH-1:0] acc;
  logic [MSE_WIDTH-1:0] acc_next;
  logic [MSE_WIDTH-1:0] entry_sum;
  logic entry_done;
  logic last_word;
  logic signed [DATA_WIDTH:0] diff_lo;
  logic signed [DATA_WIDTH:0] diff_hi;
  logic [SQ_WIDTH-1:0] sq_lo;
  logic [SQ_WIDTH-1:0] sq_hi;

  assign ref_word = captured_buf[word_cnt[BUF_AW-1:0]];
  assign last_word = (word_cnt + WCNT_ONE == words_per_pixel);

  // Unsigned samples, band 2k in the low half
  assign diff_lo = $signed({1'b0, word_data[DATA_WIDTH-1:0]})
                 - $signed({1'b0, ref_word[DATA_WIDTH-1:0]});
  assign diff_hi = $signed({1'b0, word_data[2*DATA_WIDTH-1:DATA_WIDTH]})
                 - $signed({1'b0, ref_word[2*DATA_WIDTH-1:DATA_WIDTH]});
  assign sq_lo = diff_lo * diff_lo;
  assign sq_hi = diff_hi * diff_hi;
  assign acc_next = acc + sq_lo + sq_hi;

  always_ff @(posedge clk) begin
    if (word_valid && !library_phase) captured_buf[word_cnt[BUF_AW-1:0]] <= word_data;
    if (word_valid && library_phase && last_word) entry_sum <= acc_next;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      acc <= '0;
      entry_done <= 1'b0;
      entry_idx <= '0;
      result_valid <= 1'b0;
      min_mse <= '0;
      min_index <= '0;
    end else begin
      entry_done <= word_valid && library_phase && last_word;
      result_valid <= run_end;  // Last entry compares in the run_end cycle
      if (run_start) begin
        word_cnt <= '0;
        acc <= '0;
      end else if (word_valid) begin
        word_cnt <= last_word ? '0 : word_cnt + WCNT_ONE;
        if (library_phase) acc <= last_word ? '0 : acc_next;
      end
      if (clear) begin
        min_mse <= '0;
        min_index <= '0;
      end else if (run_start) begin
        min_mse <= '1;
        min_index <= '0;
        entry_idx <= '0;
      end else if (entry_done) begin
        if (entry_sum < min_mse) begin  // Ties keep the lower index
          min_mse <= entry_sum;
          min_index <= entry_idx;
        end
        entry_idx <= entry_idx + IDX_ONE;
      end
    end
  end

endmodule

//--- hdl/hsid_top.sv
`timescale 1ns/1ps

module hsid_top #(
  parameter int WORD_WIDTH = hsid_pkg::HSID_WORD_WIDTH,
  parameter int DATA_WIDTH = hsid_pkg::HSID_DATA_WIDTH,
  parameter int HSP_BANDS_WIDTH = hsid_pkg::HSID_HSP_BANDS_WIDTH,
  parameter int HSP_LIBRARY_WIDTH = hsid_pkg::HSID_HSP_LIBRARY_WIDTH,
  parameter int MSE_WIDTH = hsid_pkg::HSID_MSE_WIDTH
) (
  input  logic clk,
  input  logic rst_n,

  input  logic [HSP_BANDS_WIDTH-1:0] pixel_bands,
  input  logic [HSP_LIBRARY_WIDTH-1:0] library_size,
  input  logic [WORD_WIDTH-1:0] captured_pixel_addr,
  input  logic [WORD_WIDTH-1:0] library_pixel_addr,
  input  logic start,
  input  logic clear,

  output logic obi_req,
  output logic [WORD_WIDTH-1:0] obi_addr,
  input  logic obi_gnt,
  input  logic obi_rvalid,
  input  logic [WORD_WIDTH-1:0] obi_rdata,

  output logic result_valid,
  output logic [MSE_WIDTH-1:0] min_mse,
  output logic [HSP_LIBRARY_WIDTH-1:0] min_index,
  output logic error,
  output logic busy
);

  logic [WORD_WIDTH-1:0] obi_initial_addr;
  logic [HSP_LIBRARY_WIDTH-1:0] obi_limit_in;  // Burst length in words
  logic obi_start;
  logic obi_done;
  logic word_valid;
  logic [WORD_WIDTH-1:0] word_data;
  logic library_phase;
  logic [HSP_BANDS_WIDTH-2:0] words_per_pixel;
  logic run_start;
  logic run_end;

  hsid_x_top_fsm #(
    .WORD_WIDTH(WORD_WIDTH),
    .HSP_BANDS_WIDTH(HSP_BANDS_WIDTH),
    .HSP_LIBRARY_WIDTH(HSP_LIBRARY_WIDTH)
  ) i_hsid_x_top_fsm (
    .clk(clk),
    .rst_n(rst_n),
    .pixel_bands(pixel_bands),
    .library_size(library_size),
    .captured_pixel_addr(captured_pixel_addr),
    .library_pixel_addr(library_pixel_addr),
    .start(start),
    .obi_initial_addr(obi_initial_addr),
    .obi_limit_in(obi_limit_in),
    .obi_start(obi_start),
    .obi_done(obi_done),
    .library_phase(library_phase),
    .words_per_pixel(words_per_pixel),
    .run_start(run_start),
    .run_end(run_end),
    .busy(busy),
    .error(error)
  );

  hsid_obi_reader #(
    .WORD_WIDTH(WORD_WIDTH),
    .HSP_LIBRARY_WIDTH(HSP_LIBRARY_WIDTH)
  ) i_hsid_obi_reader (
    .clk(clk),
    .rst_n(rst_n),
    .obi_initial_addr(obi_initial_addr),
    .obi_limit_in(obi_limit_in),
    .obi_start(obi_start),
    .obi_req(obi_req),
    .obi_addr(obi_addr),
    .obi_gnt(obi_gnt),
    .obi_rvalid(obi_rvalid),
    .obi_rdata(obi_rdata),
    .obi_done(obi_done),
    .word_valid(word_valid),
    .word_data(word_data)
  );

  hsid_mse_unit #(
    .WORD_WIDTH(WORD_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .HSP_BANDS_WIDTH(HSP_BANDS_WIDTH),
    .HSP_LIBRARY_WIDTH(HSP_LIBRARY_WIDTH),
    .MSE_WIDTH(MSE_WIDTH)
  ) i_hsid_mse_unit (
    .clk(clk),
    .rst_n(rst_n),
    .word_valid(word_valid),
    .word_data(word_data),
    .library_phase(library_phase),
    .words_per_pixel(words_per_pixel),
    .run_start(run_start),
    .run_end(run_end),
    .clear(clear),
    .result_valid(result_valid),
    .min_mse(min_mse),
    .min_index(min_index)
  );

endmodule

//--- sim/hsid_top_sva.sv
`timescale 1ns/1ps

module hsid_top_sva #(
  parameter int WORD_WIDTH = hsid_pkg::HSID_WORD_WIDTH
) (
  input logic clk,
  input logic rst_n,
  input logic obi_req,
  input logic [WORD_WIDTH-1:0] obi_addr,
  input logic obi_gnt,
  input logic obi_start,
  input logic result_valid
);

  int fail_count = 0;

  // Request waits with a steady address until granted
  req_held_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req && !obi_gnt |=> obi_req && $stable(obi_addr))
  else begin
    $error("obi_req dropped or obi_addr moved before the grant");
    fail_count++;
  end

  start_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    obi_start |=> !obi_start)
  else begin
    $error("obi_start high in two consecutive cycles");
    fail_count++;
  end

  result_not_during_req: assert property (@(posedge clk) disable iff (!rst_n)
    !(result_valid && obi_req))
  else begin
    $error("result_valid high while obi_req is high");
    fail_count++;
  end

endmodule

bind hsid_top hsid_top_sva #(
  .WORD_WIDTH(WORD_WIDTH)
) i_hsid_top_sva (
  .clk(clk),
  .rst_n(rst_n),
  .obi_req(obi_req),
  .obi_addr(obi_addr),
  .obi_gnt(obi_gnt),
  .obi_start(obi_start),
  .result_valid(result_valid)
);

//--- sim/tb_hsid_top.sv
`timescale 1ns/1ps

module tb_hsid_top;

  import hsid_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int VEC_DEPTH = 256;
  localparam int RAM_DEPTH = 1024;
  localparam int HDR_WORDS = 7;  // Record header before the data words
  localparam int SETTLE_CYCLES = 40;

  logic clk;
  logic rst_n;
  logic [HSID_HSP_BANDS_WIDTH-1:0] pixel_bands;
  logic [HSID_HSP_LIBRARY_WIDTH-1:0] library_size;
  logic [HSID_WORD_WIDTH-1:0] captured_pixel_addr;
  logic [HSID_WORD_WIDTH-1:0] library_pixel_addr;
  logic start;
  logic clear;
  logic obi_req;
  logic [HSID_WORD_WIDTH-1:0] obi_addr;
  logic obi_gnt = 1'b0;
  logic obi_rvalid = 1'b0;
  logic [HSID_WORD_WIDTH-1:0] obi_rdata = '0;
  logic result_valid;
  logic [HSID_MSE_WIDTH-1:0] min_mse;
  logic [HSID_HSP_LIBRARY_WIDTH-1:0] min_index;
  logic error;
  logic busy;

  logic [63:0] vec_mem [VEC_DEPTH];
  logic [HSID_WORD_WIDTH-1:0] ram [RAM_DEPTH];
  logic [31:0] lcg_state = 32'd7;
  int due_q [$];  // Cycle in which each pending rvalid is driven
  logic [HSID_WORD_WIDTH-1:0] rdata_q [$];
  int watchdog_cycles;
  int mismatch_count;
  int failure_count;
  int result_count;
  int req_count;

  hsid_top i_hsid_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Captured plus library words of the record at p, none for a rejected start
  function automatic int data_words(int p);
    int wpp;
    wpp = int'(vec_mem[p + 1][HSID_HSP_BANDS_WIDTH-1:1]);
    if (vec_mem[p][0]) return 0;
    return wpp * (1 + int'(vec_mem[p + 2][HSID_HSP_LIBRARY_WIDTH-1:0]));
  endfunction

  // Memory with random grant stalls and 1 to 2 cycles of read latency
  always @(posedge clk) begin : memory_model
    logic [31:0] rnd;
    int due;
    int now_cycle;
    int last_due;
    now_cycle = now_cycle + 1;
    if (!rst_n) begin
      obi_gnt <= 1'b0;
      obi_rvalid <= 1'b0;
      due_q.delete();
      rdata_q.delete();
      last_due = 0;
    end else begin
      rnd = next_random();
      if (obi_req && obi_gnt) begin
        due = now_cycle + int'(rnd[16]);
        if (due <= last_due) due = last_due + 1;  // Keep responses in order
        last_due = due;
        due_q.push_back(due);
        rdata_q.push_back(ram[obi_addr[11:2]]);
      end
      obi_gnt <= (rnd[31:30] != 2'b00);  // Stalls about one cycle in four
      if (due_q.size() > 0 && due_q[0] == now_cycle) begin
        obi_rvalid <= 1'b1;
        obi_rdata <= rdata_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        obi_rvalid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && result_valid) result_count <= result_count + 1;
    if (rst_n && obi_req) req_count <= req_count + 1;
  end

  task automatic check_mse(input logic [HSID_MSE_WIDTH-1:0] expected,
                           input logic [HSID_MSE_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: min_mse expected %0h, got %0h", $time, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_index(input logic [HSID_HSP_LIBRARY_WIDTH-1:0] expected,
                             input logic [HSID_HSP_LIBRARY_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: min_index expected %0d, got %0d", $time, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_error(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: error expected %0b, got %0b", $time, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t: %s", $time, what);
    failure_count++;
  endtask

  task automatic wait_for_result();
    do begin
      @(posedge clk);
    end while (!result_valid);
  endtask

  task automatic print_error_counts();
    $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, failure_count, i_hsid_top.i_hsid_top_sva.fail_count);
  endtask

  initial begin
    int p;
    int v;
    int i;
    int num_vec;
    int max_words;
    int wpp;
    int results_before;
    int reqs_before;
    logic [2:0] flags;
    logic [9:0] widx;
    rst_n = 1'b0;
    start = 1'b0;
    clear = 1'b0;
    pixel_bands = '0;
    library_size = '0;
    captured_pixel_addr = '0;
    library_pixel_addr = '0;
    for (i = 0; i < RAM_DEPTH; i++) begin
      ram[i] = 32'(i) * 32'h9e3779b1;
    end
    $readmemh("sim/hsid_vectors.txt", vec_mem);
    num_vec = int'(vec_mem[0][15:0]);
    p = 1;
    max_words = 0;
    for (v = 0; v < num_vec; v++) begin
      if (data_words(p) > max_words) max_words = data_words(p);
      p = p + HDR_WORDS + data_words(p);
    end
    watchdog_cycles = num_vec * max_words * 8 + 1000;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    p = 1;
    for (v = 0; v < num_vec; v++) begin
      flags = vec_mem[p][2:0];  // Error, clear after, start while busy
      wpp = int'(vec_mem[p + 1][HSID_HSP_BANDS_WIDTH-1:1]);
      for (i = 0; i < data_words(p); i++) begin
        if (i < wpp) widx = vec_mem[p + 3][11:2] + 10'(i);
        else widx = vec_mem[p + 4][11:2] + 10'(i - wpp);
        ram[widx] = vec_mem[p + HDR_WORDS + i][HSID_WORD_WIDTH-1:0];
      end
      results_before = result_count;
      reqs_before = req_count;
      @(posedge clk);
      pixel_bands <= vec_mem[p + 1][HSID_HSP_BANDS_WIDTH-1:0];
      library_size <= vec_mem[p + 2][HSID_HSP_LIBRARY_WIDTH-1:0];
      captured_pixel_addr <= vec_mem[p + 3][HSID_WORD_WIDTH-1:0];
      library_pixel_addr <= vec_mem[p + 4][HSID_WORD_WIDTH-1:0];
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
      check_error(flags[0], error);
      if (flags[0]) begin
        repeat (SETTLE_CYCLES) @(posedge clk);
        if (req_count != reqs_before) report_failure("OBI request after a rejected start");
        if (result_count != results_before) report_failure("result after a rejected start");
      end else begin
        if (!busy) report_failure("busy low after an accepted start");
        if (flags[2]) begin
          repeat (3) @(posedge clk);
          start <= 1'b1;  // Must be ignored
          @(posedge clk);
          start <= 1'b0;
        end
        wait_for_result();
        check_mse(vec_mem[p + 5][HSID_MSE_WIDTH-1:0], min_mse);
        check_index(vec_mem[p + 6][HSID_HSP_LIBRARY_WIDTH-1:0], min_index);
        repeat (SETTLE_CYCLES) @(posedge clk);
        if (result_count != results_before + 1) report_failure("run did not give one result");
        if (flags[1]) begin
          clear <= 1'b1;
          @(posedge clk);
          clear <= 1'b0;
          @(posedge clk);
          check_mse('0, min_mse);
          check_index('0, min_index);
        end
      end
      p = p + HDR_WORDS + data_words(p);
    end
    print_error_counts();
    if (mismatch_count + failure_count + i_hsid_top.i_hsid_top_sva.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    print_error_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sim/hsid_vectors.txt
// Count, then records: flags (bit0 error, bit1 clear after, bit2 start while busy), bands,
// library size, captured addr, library addr, min_mse, min_index, captured and library words
6
// Smallest sum at entry 1
0 4 3 100 200 1 1
0014000A 0028001E 0014000C 0023001E 0015000A 0028001E 00000000 00000000
// Entries 2 and 3 tie, the lower index wins
0 2 4 300 340 64 2
00C80064 00BE005A 00BE006E 00D20064 00BE0064
// Odd band count is rejected
1 3 2 600 640 0 0
// Zero band count is rejected
1 0 2 600 640 0 0
// Full scale samples, cleared afterwards
2 2 2 400 480 1FFFA0005 1
0000FFFF FFFF0000 FFFF0001
// Second start while busy is ignored
4 4 2 500 540 1 1
00020001 00040003 00020001 00060003 00020002 00040003

//--- files.f
common/hsid_pkg.sv
hdl/hsid_x_top_fsm.sv
obi_reader/hsid_obi_reader.sv
hdl/hsid_mse_unit.sv
hdl/hsid_top.sv
sim/hsid_top_sva.sv
sim/tb_hsid_top.sv

//--- Makefile
# Verilator build and run of the hyperspectral pixel identifier testbench

VERILATOR ?= verilator
TOP ?= tb_hsid_top
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
